// File: compile.f
design/decode_pkg.sv
design/inst_decoder.sv
design/regfile.sv
design/operand_forward.sv
design/branch_unit.sv
design/id_stage.sv
tb/clock_gen.sv
tb/tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_id_stage
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_id_stage.sv
module tb_id_stage import decode_pkg::*; ();

    localparam int MAX_CYCLES = 2000;   // roughly ten times the whole sequence
    localparam word_t BR_PC = 32'h0040_0100;
    localparam word_t J_PC  = 32'hbfc0_0200;

    logic        clk, reset;
    logic        ds_flush, fs_to_ds_valid, es_allowin;
    word_t       fs_pc, fs_inst;
    logic        ds_allowin, ds_to_es_valid;
    alu_op_t     alu_op;
    logic        src1_is_sa, src1_is_pc, src2_is_simm, src2_is_zimm, src2_is_8;
    logic        load_op, mem_we, gr_we;
    reg_addr_t   dest;
    logic [15:0] imm;
    word_t       rs_value, rt_value, ds_pc;
    logic        rf_we;
    reg_addr_t   rf_waddr;
    word_t       rf_wdata;
    logic        es_gr_we, ms_gr_we, ms_res_ready;
    reg_addr_t   es_dest, ms_dest;
    word_t       ms_wdata;
    logic        br_taken, br_stall;
    word_t       br_target;

    word_t  reg_model [32];   // expected register contents
    integer seed = 32'he98a_0037;
    int     cycles = 0;
    int     errors = 0;

    clock_gen u_clk (.clk(clk), .reset(reset));

    id_stage uut (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the DUT never finished the sequence", cycles);
            $display("sim failed");
            $fatal(1, "run limit reached");
        end
    end

    function automatic word_t rtype(input reg_addr_t rs, input reg_addr_t rt,
                                    input reg_addr_t rd, input reg_addr_t sa,
                                    input logic [5:0] fn);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t itype(input logic [5:0] op, input reg_addr_t rs,
                                    input reg_addr_t rt, input logic [15:0] im);
        return {op, rs, rt, im};
    endfunction

    function automatic alu_op_t onehot_op(input int pos);
        return alu_op_t'(1) << pos;
    endfunction

    // pc of the delay slot plus the word offset
    function automatic word_t rel_target(input word_t pc, input logic [15:0] off);
        return pc + 32'd4 + 32'($signed(off)) * 32'd4;
    endfunction

    task automatic value_is(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] t=%0t %s = %h, expected %h", $time, name, got, exp);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic flag_is(input string name, input logic got, input logic exp);
        value_is(name, 32'(got), 32'(exp));
    endtask

    task automatic after_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        after_edge();
        rf_we = 1'b1;
        rf_waddr = addr;
        rf_wdata = data;
        after_edge();
        rf_we = 1'b0;
        if (addr != 5'd0)
            reg_model[addr] = data;
    endtask

    // ends at the falling edge of the cycle the instruction sits in decode
    task automatic issue_inst(input word_t pc, input word_t inst);
        after_edge();
        fs_to_ds_valid = 1'b1;
        fs_pc = pc;
        fs_inst = inst;
        @(negedge clk);
        flag_is("ds_allowin", ds_allowin, 1'b1);
        after_edge();
        fs_to_ds_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic reset_state();
        @(negedge clk);
        flag_is("ds_to_es_valid", ds_to_es_valid, 1'b0);
        flag_is("br_taken", br_taken, 1'b0);
        flag_is("br_stall", br_stall, 1'b0);
        flag_is("ds_allowin", ds_allowin, 1'b1);
    endtask

    task automatic regfile_reads();
        for (int i = 1; i < 8; i++)
            write_reg(5'(i), $random(seed));
        for (int i = 1; i < 7; i += 2) begin
            issue_inst(32'h0040_0000, rtype(5'(i), 5'(i) + 5'd1, 5'd20, 5'd0, FN_ADDU));
            flag_is("ds_to_es_valid", ds_to_es_valid, 1'b1);
            value_is("rs_value", rs_value, reg_model[5'(i)]);
            value_is("rt_value", rt_value, reg_model[5'(i) + 5'd1]);
        end
        write_reg(5'd0, 32'hdead_beef);
        issue_inst(32'h0040_0010, rtype(5'd0, 5'd7, 5'd20, 5'd0, FN_ADDU));
        value_is("rs_value", rs_value, 32'h0);
        value_is("rt_value", rt_value, reg_model[7]);
    endtask

    // sels in order sa pc simm zimm 8
    // mem_wb in order load store write
    task automatic expect_controls(input word_t inst, input alu_op_t exp_op,
                                   input logic [4:0] sels, input logic [2:0] mem_wb,
                                   input reg_addr_t exp_dest);
        issue_inst(32'h0040_1000, inst);
        value_is("alu_op", 32'(alu_op), 32'(exp_op));
        flag_is("src1_is_sa", src1_is_sa, sels[4]);
        flag_is("src1_is_pc", src1_is_pc, sels[3]);
        flag_is("src2_is_simm", src2_is_simm, sels[2]);
        flag_is("src2_is_zimm", src2_is_zimm, sels[1]);
        flag_is("src2_is_8", src2_is_8, sels[0]);
        flag_is("load_op", load_op, mem_wb[2]);
        flag_is("mem_we", mem_we, mem_wb[1]);
        flag_is("gr_we", gr_we, mem_wb[0]);
        value_is("dest", 32'(dest), 32'(exp_dest));
        value_is("imm", 32'(imm), 32'(inst[15:0]));
    endtask

    task automatic decode_controls();
        expect_controls(itype(OP_ADDIU, 5'd2, 5'd4, 16'h8123), onehot_op(ALU_ADD),
                        5'b00100, 3'b001, 5'd4);
        expect_controls(itype(OP_ORI, 5'd1, 5'd7, 16'h00f0), onehot_op(ALU_OR),
                        5'b00010, 3'b001, 5'd7);
        expect_controls(itype(OP_LUI, 5'd0, 5'd9, 16'h1234), onehot_op(ALU_LUI),
                        5'b00100, 3'b001, 5'd9);
        expect_controls(rtype(5'd0, 5'd11, 5'd10, 5'd3, FN_SLL), onehot_op(ALU_SLL),
                        5'b10000, 3'b001, 5'd10);
        expect_controls(itype(OP_LW, 5'd3, 5'd12, 16'h0010), onehot_op(ALU_ADD),
                        5'b00100, 3'b101, 5'd12);
        expect_controls(itype(OP_SW, 5'd3, 5'd13, 16'hfffc), onehot_op(ALU_ADD),
                        5'b00100, 3'b010, 5'd0);
        expect_controls({OP_JAL, 26'h012_3456}, onehot_op(ALU_ADD), 5'b01001, 3'b001, REG_RA);
        expect_controls({6'h3f, 26'h3ff_ffff}, 12'h0, 5'b00000, 3'b000, 5'd0);  // not decoded
    endtask

    task automatic forwarding_paths();
        word_t v_ms;
        word_t v_wb;
        v_ms = $random(seed);
        v_wb = $random(seed);
        after_edge();
        es_allowin = 1'b0;   // keep the addu in decode
        issue_inst(32'h0040_2000, rtype(5'd5, 5'd6, 5'd3, 5'd0, FN_ADDU));
        after_edge();
        ms_gr_we = 1'b1;
        ms_dest = 5'd5;
        ms_res_ready = 1'b1;
        ms_wdata = v_ms;
        @(negedge clk);
        value_is("rs_value", rs_value, v_ms);
        value_is("rt_value", rt_value, reg_model[6]);
        after_edge();
        ms_gr_we = 1'b0;
        rf_we = 1'b1;
        rf_waddr = 5'd6;
        rf_wdata = v_wb;
        @(negedge clk);
        value_is("rt_value", rt_value, v_wb);
        value_is("rs_value", rs_value, reg_model[5]);
        reg_model[6] = v_wb;
        after_edge();
        ms_gr_we = 1'b1;
        ms_dest = 5'd6;   // both ports now hit rt
        @(negedge clk);
        value_is("rt_value", rt_value, v_ms);
        after_edge();
        es_allowin = 1'b1;
        es_gr_we = 1'b1;
        es_dest = 5'd0;
        ms_dest = 5'd0;
        rf_waddr = 5'd0;
        issue_inst(32'h0040_2004, rtype(5'd0, 5'd0, 5'd3, 5'd0, FN_ADDU));
        value_is("rs_value", rs_value, 32'h0);
        value_is("rt_value", rt_value, 32'h0);
        flag_is("br_stall", br_stall, 1'b0);
        after_edge();
        es_gr_we = 1'b0;
        ms_gr_we = 1'b0;
        rf_we = 1'b0;
    endtask

    task automatic hazard_stall();
        word_t v;
        v = $random(seed);
        after_edge();
        es_gr_we = 1'b1;
        es_dest = 5'd6;
        issue_inst(32'h0040_3000, rtype(5'd5, 5'd6, 5'd3, 5'd0, FN_ADDU));
        flag_is("ds_to_es_valid", ds_to_es_valid, 1'b0);
        flag_is("br_stall", br_stall, 1'b1);
        flag_is("ds_allowin", ds_allowin, 1'b0);
        @(negedge clk);
        flag_is("br_stall", br_stall, 1'b1);
        after_edge();
        es_gr_we = 1'b0;
        @(negedge clk);
        flag_is("ds_to_es_valid", ds_to_es_valid, 1'b1);
        flag_is("br_stall", br_stall, 1'b0);
        // load result still in memory stage
        after_edge();
        ms_gr_we = 1'b1;
        ms_dest = 5'd5;
        ms_res_ready = 1'b0;
        ms_wdata = v;
        issue_inst(32'h0040_3004, rtype(5'd5, 5'd6, 5'd3, 5'd0, FN_ADDU));
        flag_is("ds_to_es_valid", ds_to_es_valid, 1'b0);
        flag_is("br_stall", br_stall, 1'b1);
        flag_is("ds_allowin", ds_allowin, 1'b0);
        after_edge();
        ms_res_ready = 1'b1;
        @(negedge clk);
        flag_is("ds_to_es_valid", ds_to_es_valid, 1'b1);
        value_is("rs_value", rs_value, v);
        after_edge();
        ms_gr_we = 1'b0;
    endtask

    task automatic branch_case(input word_t pc, input word_t inst, input logic take,
                               input word_t target);
        issue_inst(pc, inst);
        flag_is("ds_to_es_valid", ds_to_es_valid, 1'b1);
        flag_is("br_taken", br_taken, take);
        if (take)
            value_is("br_target", br_target, target);
    endtask

    task automatic branch_resolution();
        word_t a;
        a = $random(seed);
        write_reg(5'd8, a);
        write_reg(5'd9, a);
        write_reg(5'd10, a ^ 32'h1);
        write_reg(5'd11, a | 32'h8000_0000);
        write_reg(5'd12, 32'h0);
        branch_case(BR_PC, itype(OP_BEQ, 5'd8, 5'd9, 16'h0010), 1'b1,
                    rel_target(BR_PC, 16'h0010));
        branch_case(BR_PC, itype(OP_BEQ, 5'd8, 5'd10, 16'h0010), 1'b0, 32'h0);
        branch_case(BR_PC, itype(OP_REGIMM, 5'd11, RT_BLTZ, 16'hfff8), 1'b1,
                    rel_target(BR_PC, 16'hfff8));
        branch_case(BR_PC, itype(OP_REGIMM, 5'd12, RT_BLTZ, 16'hfff8), 1'b0, 32'h0);
        branch_case(BR_PC, itype(OP_REGIMM, 5'd12, RT_BGEZ, 16'h0100), 1'b1,
                    rel_target(BR_PC, 16'h0100));
        branch_case(BR_PC, itype(OP_REGIMM, 5'd11, RT_BGEZ, 16'h0100), 1'b0, 32'h0);
        branch_case(J_PC, {OP_J, 26'h12a_5a5c}, 1'b1, {J_PC[31:28], 26'h12a_5a5c, 2'b00});
        branch_case(J_PC, rtype(5'd8, 5'd0, 5'd0, 5'd0, FN_JR), 1'b1, a);
    endtask

    task automatic backpressure_flush();
        word_t   held_target;
        alu_op_t held_op;
        after_edge();
        es_allowin = 1'b0;
        issue_inst(BR_PC, itype(OP_BEQ, 5'd8, 5'd9, 16'h0010));
        flag_is("br_taken", br_taken, 1'b0);
        flag_is("ds_allowin", ds_allowin, 1'b0);
        value_is("ds_pc", ds_pc, BR_PC);
        held_target = br_target;
        held_op = alu_op;
        after_edge();
        fs_to_ds_valid = 1'b1;   // a fetch that must wait
        fs_pc = 32'h0040_0200;
        fs_inst = itype(OP_ORI, 5'd1, 5'd7, 16'h00f0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        value_is("ds_pc", ds_pc, BR_PC);
        value_is("br_target", br_target, held_target);
        value_is("alu_op", 32'(alu_op), 32'(held_op));
        flag_is("br_taken", br_taken, 1'b0);
        after_edge();
        es_allowin = 1'b1;
        ds_flush = 1'b1;   // the waiting fetch stays valid
        @(negedge clk);
        flag_is("br_taken", br_taken, 1'b0);
        after_edge();
        fs_to_ds_valid = 1'b0;
        ds_flush = 1'b0;
        @(negedge clk);
        flag_is("ds_to_es_valid", ds_to_es_valid, 1'b0);
        flag_is("ds_allowin", ds_allowin, 1'b1);
    endtask

    initial begin
        foreach (reg_model[k])
            reg_model[k] = '0;
        ds_flush = 1'b0;
        fs_to_ds_valid = 1'b0;
        fs_pc = '0;
        fs_inst = '0;
        es_allowin = 1'b1;
        rf_we = 1'b0;
        rf_waddr = '0;
        rf_wdata = '0;
        es_gr_we = 1'b0;
        es_dest = '0;
        ms_gr_we = 1'b0;
        ms_dest = '0;
        ms_res_ready = 1'b0;
        ms_wdata = '0;
        wait (reset === 1'b0);
        reset_state();
        regfile_reads();
        decode_controls();
        forwarding_paths();
        hazard_stall();
        branch_resolution();
        backpressure_flush();
        repeat (2) @(posedge clk);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: tb/clock_gen.sv
module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;   // released with the other inputs
    end

endmodule

// File: design/id_stage.sv
module id_stage import decode_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        ds_flush,
    input  logic        fs_to_ds_valid,
    input  word_t       fs_pc,
    input  word_t       fs_inst,
    output logic        ds_allowin,
    input  logic        es_allowin,
    output logic        ds_to_es_valid,
    output alu_op_t     alu_op,
    output logic        src1_is_sa,
    output logic        src1_is_pc,
    output logic        src2_is_simm,
    output logic        src2_is_zimm,
    output logic        src2_is_8,
    output logic        load_op,
    output logic        mem_we,
    output logic        gr_we,
    output reg_addr_t   dest,
    output logic [15:0] imm,
    output word_t       rs_value,
    output word_t       rt_value,
    output word_t       ds_pc,
    input  logic        rf_we,
    input  reg_addr_t   rf_waddr,
    input  word_t       rf_wdata,
    input  logic        es_gr_we,
    input  reg_addr_t   es_dest,
    input  logic        ms_gr_we,
    input  reg_addr_t   ms_dest,
    input  logic        ms_res_ready,
    input  word_t       ms_wdata,
    output logic        br_taken,
    output word_t       br_target,
    output logic        br_stall
);

    logic        ds_valid;
    logic        ds_ready_go;
    word_t       ds_inst;
    reg_addr_t   rs;
    reg_addr_t   rt;
    logic        read_rs;
    logic        read_rt;
    logic [25:0] jidx;
    logic        is_beq, is_bne, is_bgez, is_bgtz, is_blez, is_bltz;
    logic        is_jr_jalr, is_j_jal;
    word_t       rf_rdata1;
    word_t       rf_rdata2;
    logic        hazard;
    logic        br_take;

    assign ds_ready_go    = ~hazard;
    assign ds_allowin     = ~ds_valid | (ds_ready_go & es_allowin);
    assign ds_to_es_valid = ds_valid & ds_ready_go;
    assign br_stall       = ds_valid & ~ds_ready_go;
    assign br_taken       = br_take & ds_to_es_valid & es_allowin & ~ds_flush;

    always_ff @(posedge clk) begin
        if (reset)
            ds_valid <= 1'b0;
        else if (ds_flush)
            ds_valid <= 1'b0;   // flush beats a new fetch
        else if (ds_allowin)
            ds_valid <= fs_to_ds_valid;
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin && !ds_flush) begin
            ds_pc   <= fs_pc;
            ds_inst <= fs_inst;
        end
    end

    inst_decoder u_decoder (
        .inst(ds_inst), .rs(rs), .rt(rt), .alu_op(alu_op),
        .src1_is_sa(src1_is_sa), .src1_is_pc(src1_is_pc),
        .src2_is_simm(src2_is_simm), .src2_is_zimm(src2_is_zimm), .src2_is_8(src2_is_8),
        .load_op(load_op), .mem_we(mem_we), .gr_we(gr_we), .dest(dest), .imm(imm),
        .read_rs(read_rs), .read_rt(read_rt), .jidx(jidx),
        .is_beq(is_beq), .is_bne(is_bne), .is_bgez(is_bgez), .is_bgtz(is_bgtz),
        .is_blez(is_blez), .is_bltz(is_bltz), .is_jr_jalr(is_jr_jalr), .is_j_jal(is_j_jal)
    );

    regfile u_regfile (
        .clk(clk), .raddr1(rs), .raddr2(rt), .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    operand_forward u_forward (
        .rs(rs), .rt(rt), .read_rs(read_rs), .read_rt(read_rt),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .es_gr_we(es_gr_we), .es_dest(es_dest),
        .ms_gr_we(ms_gr_we), .ms_dest(ms_dest), .ms_res_ready(ms_res_ready),
        .ms_wdata(ms_wdata), .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .rs_value(rs_value), .rt_value(rt_value), .hazard(hazard)
    );

    branch_unit u_branch (
        .pc(ds_pc), .imm(imm), .jidx(jidx), .rs_value(rs_value), .rt_value(rt_value),
        .is_beq(is_beq), .is_bne(is_bne), .is_bgez(is_bgez), .is_bgtz(is_bgtz),
        .is_blez(is_blez), .is_bltz(is_bltz), .is_jr_jalr(is_jr_jalr), .is_j_jal(is_j_jal),
        .take(br_take), .target(br_target)
    );

    a_valid_out: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> ds_valid);

    a_taken_not_stalled: assert property (@(posedge clk) disable iff (reset)
        br_stall |-> !br_taken);

    // a held instruction survives back-pressure
    a_hold: assert property (@(posedge clk) disable iff (reset)
        ds_valid && !ds_allowin && !ds_flush |=> ds_valid && $stable(ds_pc));

endmodule

// File: design/branch_unit.sv
module branch_unit import decode_pkg::*; (
    input  word_t       pc,
    input  logic [15:0] imm,
    input  logic [25:0] jidx,
    input  word_t       rs_value,
    input  word_t       rt_value,
    input  logic        is_beq,
    input  logic        is_bne,
    input  logic        is_bgez,
    input  logic        is_bgtz,
    input  logic        is_blez,
    input  logic        is_bltz,
    input  logic        is_jr_jalr,
    input  logic        is_j_jal,
    output logic        take,
    output word_t       target
);

    logic  rs_eq_rt;
    logic  rs_lt_zero;
    logic  rs_eq_zero;
    logic  cond_branch;
    word_t br_offset;

    assign rs_eq_rt   = (rs_value == rt_value);
    assign rs_lt_zero = rs_value[31];
    assign rs_eq_zero = (rs_value == '0);

    assign cond_branch = is_beq | is_bne | is_bgez | is_bgtz | is_blez | is_bltz;

    assign take = is_beq  &  rs_eq_rt
                | is_bne  & ~rs_eq_rt
                | is_bgez & ~rs_lt_zero
                | is_bgtz & ~rs_lt_zero & ~rs_eq_zero
                | is_blez & (rs_lt_zero | rs_eq_zero)
                | is_bltz &  rs_lt_zero
                | is_jr_jalr
                | is_j_jal;

    assign br_offset = {{14{imm[15]}}, imm, 2'b00};   // word offset, sign extended

    always_comb begin
        if (cond_branch)
            target = pc + 32'd4 + br_offset;   // relative to the delay slot
        else if (is_jr_jalr)
            target = rs_value;
        else
            target = {pc[31:28], jidx, 2'b00};
    end

endmodule

// File: design/operand_forward.sv
module operand_forward import decode_pkg::*; (
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  logic      read_rs,
    input  logic      read_rt,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    input  logic      es_gr_we,
    input  reg_addr_t es_dest,
    input  logic      ms_gr_we,
    input  reg_addr_t ms_dest,
    input  logic      ms_res_ready,
    input  word_t     ms_wdata,
    input  logic      rf_we,
    input  reg_addr_t rf_waddr,
    input  word_t     rf_wdata,
    output word_t     rs_value,
    output word_t     rt_value,
    output logic      hazard
);

    logic rs_es, rs_ms, rs_ws;
    logic rt_es, rt_ms, rt_ws;

    function automatic logic dest_hit(input reg_addr_t src, input logic we,
                                      input reg_addr_t dst);
        return we && (src != '0) && (src == dst);
    endfunction

    assign rs_es = dest_hit(rs, es_gr_we, es_dest);
    assign rs_ms = dest_hit(rs, ms_gr_we, ms_dest);
    assign rs_ws = dest_hit(rs, rf_we, rf_waddr);
    assign rt_es = dest_hit(rt, es_gr_we, es_dest);
    assign rt_ms = dest_hit(rt, ms_gr_we, ms_dest);
    assign rt_ws = dest_hit(rt, rf_we, rf_waddr);

    // newest producer first
    assign rs_value = (rs_ms && ms_res_ready) ? ms_wdata :
                      rs_ws                   ? rf_wdata :
                                                rf_rdata1;
    assign rt_value = (rt_ms && ms_res_ready) ? ms_wdata :
                      rt_ws                   ? rf_wdata :
                                                rf_rdata2;

    // execute result never ready in decode, load data not ready in memory
    assign hazard = read_rs & (rs_es | (rs_ms & ~ms_res_ready))
                  | read_rt & (rt_es | (rt_ms & ~ms_res_ready));

endmodule

// File: design/regfile.sv
module regfile import decode_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    word_t rf [32];

    always_ff @(posedge clk) begin
        if (we)
            rf[waddr] <= wdata;
    end

    // r0 reads zero whatever was written
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

// File: design/inst_decoder.sv
module inst_decoder import decode_pkg::*; (
    input  word_t       inst,
    output reg_addr_t   rs,
    output reg_addr_t   rt,
    output alu_op_t     alu_op,
    output logic        src1_is_sa,
    output logic        src1_is_pc,
    output logic        src2_is_simm,
    output logic        src2_is_zimm,
    output logic        src2_is_8,
    output logic        load_op,
    output logic        mem_we,
    output logic        gr_we,
    output reg_addr_t   dest,
    output logic [15:0] imm,
    output logic        read_rs,
    output logic        read_rt,
    output logic [25:0] jidx,
    output logic        is_beq,
    output logic        is_bne,
    output logic        is_bgez,
    output logic        is_bgtz,
    output logic        is_blez,
    output logic        is_bltz,
    output logic        is_jr_jalr,
    output logic        is_j_jal
);

    logic [5:0] op;
    logic [5:0] func;
    reg_addr_t  rd;
    reg_addr_t  sa;
    logic       r_arith;
    logic       r_shift;
    logic       inst_add, inst_addu, inst_sub, inst_subu, inst_slt, inst_sltu;
    logic       inst_and, inst_or, inst_xor, inst_nor;
    logic       inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
    logic       inst_addi, inst_addiu, inst_slti, inst_sltiu;
    logic       inst_andi, inst_ori, inst_xori, inst_lui;
    logic       inst_jr, inst_jalr, inst_j, inst_jal;
    logic       alu_rr;
    logic       alu_ri;

    assign op   = inst[31:26];
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign func = inst[5:0];
    assign imm  = inst[15:0];
    assign jidx = inst[25:0];

    assign r_arith = (op == OP_SPECIAL) && (sa == '0);
    assign r_shift = (op == OP_SPECIAL) && (rs == '0);   // shift amount in sa

    assign inst_add   = r_arith && (func == FN_ADD);
    assign inst_addu  = r_arith && (func == FN_ADDU);
    assign inst_sub   = r_arith && (func == FN_SUB);
    assign inst_subu  = r_arith && (func == FN_SUBU);
    assign inst_slt   = r_arith && (func == FN_SLT);
    assign inst_sltu  = r_arith && (func == FN_SLTU);
    assign inst_and   = r_arith && (func == FN_AND);
    assign inst_or    = r_arith && (func == FN_OR);
    assign inst_xor   = r_arith && (func == FN_XOR);
    assign inst_nor   = r_arith && (func == FN_NOR);
    assign inst_sllv  = r_arith && (func == FN_SLLV);
    assign inst_srlv  = r_arith && (func == FN_SRLV);
    assign inst_srav  = r_arith && (func == FN_SRAV);
    assign inst_sll   = r_shift && (func == FN_SLL);
    assign inst_srl   = r_shift && (func == FN_SRL);
    assign inst_sra   = r_shift && (func == FN_SRA);
    assign inst_jr    = r_arith && (func == FN_JR) && (rt == '0) && (rd == '0);
    assign inst_jalr  = r_arith && (func == FN_JALR) && (rt == '0);
    assign inst_addi  = (op == OP_ADDI);
    assign inst_addiu = (op == OP_ADDIU);
    assign inst_slti  = (op == OP_SLTI);
    assign inst_sltiu = (op == OP_SLTIU);
    assign inst_andi  = (op == OP_ANDI);
    assign inst_ori   = (op == OP_ORI);
    assign inst_xori  = (op == OP_XORI);
    assign inst_lui   = (op == OP_LUI) && (rs == '0);
    assign inst_j     = (op == OP_J);
    assign inst_jal   = (op == OP_JAL);
    assign load_op    = (op == OP_LW);
    assign mem_we     = (op == OP_SW);

    assign is_beq     = (op == OP_BEQ);
    assign is_bne     = (op == OP_BNE);
    assign is_bgez    = (op == OP_REGIMM) && (rt == RT_BGEZ);
    assign is_bltz    = (op == OP_REGIMM) && (rt == RT_BLTZ);
    assign is_bgtz    = (op == OP_BGTZ) && (rt == '0);
    assign is_blez    = (op == OP_BLEZ) && (rt == '0);
    assign is_jr_jalr = inst_jr | inst_jalr;
    assign is_j_jal   = inst_j | inst_jal;

    // register-register and register-immediate alu forms
    assign alu_rr = inst_add | inst_addu | inst_sub | inst_subu | inst_slt | inst_sltu
                  | inst_and | inst_or | inst_xor | inst_nor | src1_is_sa
                  | inst_sllv | inst_srlv | inst_srav;
    assign alu_ri = inst_addi | inst_addiu | inst_slti | inst_sltiu
                  | inst_andi | inst_ori | inst_xori | inst_lui;

    always_comb begin
        alu_op           = '0;
        alu_op[ALU_ADD]  = inst_add | inst_addu | inst_addi | inst_addiu
                         | load_op | mem_we | inst_jal | inst_jalr;
        alu_op[ALU_SUB]  = inst_sub | inst_subu;
        alu_op[ALU_SLT]  = inst_slt | inst_slti;
        alu_op[ALU_SLTU] = inst_sltu | inst_sltiu;
        alu_op[ALU_AND]  = inst_and | inst_andi;
        alu_op[ALU_NOR]  = inst_nor;
        alu_op[ALU_OR]   = inst_or | inst_ori;
        alu_op[ALU_XOR]  = inst_xor | inst_xori;
        alu_op[ALU_SLL]  = inst_sll | inst_sllv;
        alu_op[ALU_SRL]  = inst_srl | inst_srlv;
        alu_op[ALU_SRA]  = inst_sra | inst_srav;
        alu_op[ALU_LUI]  = inst_lui;
    end

    assign src1_is_sa   = inst_sll | inst_srl | inst_sra;
    assign src1_is_pc   = inst_jal | inst_jalr;          // link address pc + 8
    assign src2_is_8    = inst_jal | inst_jalr;
    assign src2_is_simm = inst_addi | inst_addiu | inst_slti | inst_sltiu | inst_lui
                        | load_op | mem_we;
    assign src2_is_zimm = inst_andi | inst_ori | inst_xori;

    assign gr_we   = alu_rr | alu_ri | load_op | inst_jal | inst_jalr;
    assign read_rs = (alu_rr & ~src1_is_sa) | (alu_ri & ~inst_lui) | load_op | mem_we
                   | is_beq | is_bne | is_bgez | is_bgtz | is_blez | is_bltz | is_jr_jalr;
    assign read_rt = alu_rr | mem_we | is_beq | is_bne;

    assign dest = !gr_we               ? '0     :
                  (inst_jal | inst_jalr) ? REG_RA :
                  (alu_ri | load_op)   ? rt     :
                                         rd;

    // decode terms never overlap
    always_comb begin
        if (!$isunknown(alu_op))
            a_alu_onehot: assert final ($onehot0(alu_op));
    end

endmodule

// File: design/decode_pkg.sv
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_op_t;     // one-hot, bits below

    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // primary opcodes, inst[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function field of SPECIAL, inst[5:0]
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    localparam reg_addr_t RT_BLTZ = 5'h00;   // REGIMM rt selectors
    localparam reg_addr_t RT_BGEZ = 5'h01;

    localparam reg_addr_t REG_RA  = 5'd31;   // link register

endpackage
